// File: dma_bus_pkg.sv
package dma_bus_pkg;

   typedef logic [31:0] wb_adr_t;    // byte address
   typedef logic [31:0] wb_dat_t;    // one 32-bit half of a 64-bit beat
   typedef logic [3:0]  wb_sel_t;
   typedef logic [28:0] desc_ptr_t;  // 64-bit word address, bits 31..3
   typedef logic [1:0]  beat_t;      // beat index inside a burst
   typedef logic [2:0]  reg_adr_t;   // register word address

   localparam int BURST_BEATS = 4;   // every burst is four beats
   localparam wb_sel_t WB_SEL_ALL = 4'b1111;

   // software register map
   localparam reg_adr_t REG_NDAR   = 3'd0;
   localparam reg_adr_t REG_CSR    = 3'd1;
   localparam reg_adr_t REG_INTCLR = 3'd2;
   localparam reg_adr_t REG_DAR    = 3'd3;

endpackage

// File: dma_desc_pkg.sv
package dma_desc_pkg;

   typedef logic [23:0] desc_ctl_t;  // descriptor control word
   typedef logic [15:0] ocnt_t;      // stage word count

   // where things sit inside a fetched descriptor
   localparam int DC_PTR_BEAT = 0;   // next pointer low, status address high
   localparam int DC_CTL_BEAT = 1;   // control word in the low half

   // control word fields
   localparam int DC_LEN_LSB    = 16;
   localparam int DC_LEN_W      = 8;
   localparam int DC_IRQ_BIT    = 15;
   localparam int DC_LINK_BIT   = 14;
   localparam int DC_STATUS_BIT = 7;

   typedef enum logic [3:0] {
      IDLE  = 4'h0,
      CMD0  = 4'h1,  // fetch descriptor for stage 0
      NEXT0 = 4'h2,
      CMD1  = 4'h3,  // fetch linked descriptor for stage 1
      WAIT0 = 4'h4,
      CTL0  = 4'h5,  // status write-back of stage 0
      TR0   = 4'h6,
      WAIT1 = 4'h7,
      CTL1  = 4'h8,
      TR1   = 4'h9,
      NEXT1 = 4'ha
   } ctrl_state_e;

endpackage

// File: dma_regs.sv
`timescale 1ns/100ps

module dma_regs (
   input  logic                   wb_clk_i,
   input  logic                   wb_rst_i,
   input  logic                   reg_we_i,
   input  dma_bus_pkg::reg_adr_t  reg_adr_i,
   input  dma_bus_pkg::wb_dat_t   reg_dat_i,
   output dma_bus_pkg::wb_dat_t   reg_dat_o,
   output dma_bus_pkg::desc_ptr_t ndar_o,
   output logic                   ndar_dirty_o,
   input  logic                   ndar_dirty_clear_i,
   output logic                   enable_o,
   output logic                   append_o,
   input  logic                   append_clear_i,
   output logic                   int_clear_o,
   input  dma_bus_pkg::wb_adr_t   dar_i,
   input  logic                   busy_i
);
   import dma_bus_pkg::*;

   logic wr_ndar;
   logic wr_csr;

   assign wr_ndar     = reg_we_i && (reg_adr_i == REG_NDAR);
   assign wr_csr      = reg_we_i && (reg_adr_i == REG_CSR);
   assign int_clear_o = reg_we_i && (reg_adr_i == REG_INTCLR);  // seen by ctrl this cycle

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         ndar_o       <= '0;
         ndar_dirty_o <= 1'b0;
         enable_o     <= 1'b0;
         append_o     <= 1'b0;
      end else begin
         if (ndar_dirty_clear_i)
            ndar_dirty_o <= 1'b0;
         if (wr_ndar) begin
            ndar_o       <= reg_dat_i[31:3];
            ndar_dirty_o <= 1'b1;  // a new write wins over the clear
         end
         if (append_clear_i)
            append_o <= 1'b0;
         if (wr_csr) begin
            enable_o <= reg_dat_i[0];
            if (reg_dat_i[1])
               append_o <= 1'b1;  // only the controller drops it
         end
      end
   end

   always_comb begin
      reg_dat_o = '0;
      case (reg_adr_i)
         REG_NDAR: reg_dat_o = {ndar_o, 3'b000};
         REG_CSR:  reg_dat_o = {29'd0, busy_i, append_o, enable_o};
         REG_DAR:  reg_dat_o = dar_i;
         default:  reg_dat_o = '0;  // interrupt clear reads as zero
      endcase
   end

endmodule

// File: dma_stage.sv
`timescale 1ns/100ps

module dma_stage (
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   input  logic                  stg_we_i,
   input  dma_bus_pkg::beat_t    stg_adr_i,
   input  dma_bus_pkg::wb_dat_t  stg_dat_i,
   input  logic                  stg_run_i,
   input  logic                  stg_done_i,
   output logic                  c_done_o,
   output dma_desc_pkg::ocnt_t   ocnt_o
);
   import dma_bus_pkg::*;
   import dma_desc_pkg::*;

   wb_dat_t               words_q [BURST_BEATS];  // low halves of the descriptor
   logic [DC_LEN_W-1:0]   len_w;
   logic [DC_LEN_W-1:0]   cnt_q;
   logic                  run_q;
   logic                  run_rise;
   logic                  active_q;

   always_ff @(posedge wb_clk_i) begin
      if (stg_we_i)
         words_q[stg_adr_i] <= stg_dat_i;
   end

   assign len_w    = words_q[DC_CTL_BEAT][DC_LEN_LSB +: DC_LEN_W];
   assign run_rise = stg_run_i && !run_q;

   // done lands length+1 cycles after run rises
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         run_q    <= 1'b0;
         active_q <= 1'b0;
         cnt_q    <= '0;
         c_done_o <= 1'b0;
         ocnt_o   <= '0;
      end else begin
         run_q <= stg_run_i;
         if (stg_done_i) begin
            c_done_o <= 1'b0;
            active_q <= 1'b0;
         end else if (run_rise) begin
            ocnt_o <= '0;
            if (len_w == '0) begin
               c_done_o <= 1'b1;  // empty transfer
            end else begin
               cnt_q    <= len_w - 1'b1;
               active_q <= 1'b1;
            end
         end else if (active_q) begin
            ocnt_o <= ocnt_o + 1'b1;  // one word per cycle
            if (cnt_q == '0) begin
               c_done_o <= 1'b1;
               active_q <= 1'b0;
            end else begin
               cnt_q <= cnt_q - 1'b1;
            end
         end
      end
   end

endmodule

// File: dma_ctrl.sv
`timescale 1ns/100ps

module dma_ctrl (
   input  logic                   wb_clk_i,
   input  logic                   wb_rst_i,
   output logic                   wbm_cyc_o,
   output logic                   wbm_stb_o,
   output logic                   wbm_we_o,
   output logic                   wbm_cab_o,
   output dma_bus_pkg::wb_sel_t   wbm_sel_o,
   output dma_bus_pkg::wb_adr_t   wbm_adr_o,
   output dma_bus_pkg::wb_dat_t   wbm_dat_lo_o,
   output dma_bus_pkg::wb_dat_t   wbm_dat_hi_o,
   input  dma_bus_pkg::wb_dat_t   wbm_dat_lo_i,
   input  dma_bus_pkg::wb_dat_t   wbm_dat_hi_i,
   input  logic                   wbm_ack_i,
   input  logic                   wbm_err_i,
   input  logic                   wbm_rty_i,
   input  dma_bus_pkg::desc_ptr_t ndar_i,
   input  logic                   ndar_dirty_i,
   output logic                   ndar_dirty_clear_o,
   input  logic                   enable_i,
   input  logic                   append_i,
   output logic                   append_clear_o,
   input  logic                   int_clear_i,
   output dma_bus_pkg::wb_adr_t   dar_o,
   output logic                   stg0_we_o,
   output logic                   stg1_we_o,
   output dma_bus_pkg::beat_t     stg_adr_o,
   output dma_bus_pkg::wb_dat_t   stg_dat_o,
   output logic                   stg0_run_o,
   output logic                   stg1_run_o,
   output logic                   stg0_done_o,
   output logic                   stg1_done_o,
   input  logic                   c_done0_i,
   input  logic                   c_done1_i,
   input  dma_desc_pkg::ocnt_t    ocnt0_i,
   input  dma_desc_pkg::ocnt_t    ocnt1_i,
   output logic                   busy_o,
   output logic                   wb_int_o
);
   import dma_bus_pkg::*;
   import dma_desc_pkg::*;

   ctrl_state_e state_q;
   ctrl_state_e state_n;
   logic        cyc_q;
   logic        stb_q;
   logic        we_q;
   desc_ptr_t   adr_q;
   beat_t       beat_q;
   logic        ack_ok;
   logic        last_beat;
   logic        start_rd;
   logic        start_wr;
   desc_ptr_t   start_adr;
   logic        append_mode_q;
   logic        append_mode_n;
   logic        dirty_clear_n;
   logic        append_clear_n;
   logic        run0_start;
   logic        run1_start;
   logic        int_set;
   desc_ptr_t   next_desc_q;
   desc_ptr_t   ctl_adr0_q;
   desc_ptr_t   ctl_adr1_q;
   desc_ptr_t   cdar0_q;
   desc_ptr_t   cdar1_q;
   desc_ptr_t   dar_q;
   desc_ctl_t   dc0_q;
   desc_ctl_t   dc1_q;
   wb_dat_t     cyc0_q;
   wb_dat_t     cyc1_q;
   ocnt_t       stat_ocnt;
   wb_dat_t     stat_cyc;
   desc_ctl_t   stat_dc;
   wb_dat_t     stat_word;

   assign ack_ok    = cyc_q && stb_q && wbm_ack_i && !wbm_err_i && !wbm_rty_i;
   assign last_beat = ack_ok && (beat_q == beat_t'(BURST_BEATS - 1));

   always_comb begin
      state_n        = state_q;
      start_rd       = 1'b0;
      start_wr       = 1'b0;
      start_adr      = next_desc_q;
      append_mode_n  = append_mode_q;
      dirty_clear_n  = 1'b0;
      append_clear_n = 1'b0;
      run0_start     = 1'b0;
      case (state_q)
         IDLE: begin
            if (enable_i && ndar_dirty_i) begin
               start_rd      = 1'b1;
               start_adr     = ndar_i;
               dirty_clear_n = 1'b1;
               state_n       = CMD0;
            end else if (enable_i && append_i) begin
               start_rd       = 1'b1;
               start_adr      = dar_q;  // re-read the last finished descriptor
               append_mode_n  = 1'b1;
               append_clear_n = 1'b1;
               state_n        = CMD0;
            end
         end
         CMD0: if (last_beat) state_n = NEXT0;
         NEXT0: begin
            if (dc0_q[DC_LINK_BIT]) begin
               start_rd = 1'b1;
               state_n  = append_mode_q ? CMD0 : CMD1;
            end else begin
               state_n  = append_mode_q ? IDLE : WAIT0;  // nothing new to run
            end
            if (append_mode_q)
               append_mode_n = 1'b0;
            else
               run0_start = 1'b1;
         end
         CMD1: if (last_beat) state_n = WAIT0;
         WAIT0: begin
            if (c_done0_i) begin
               if (dc0_q[DC_STATUS_BIT]) begin
                  start_wr  = 1'b1;
                  start_adr = ctl_adr0_q;
                  state_n   = CTL0;
               end else begin
                  state_n   = TR0;
               end
            end
         end
         CTL0: if (last_beat) state_n = TR0;
         TR0: state_n = dc0_q[DC_LINK_BIT] ? WAIT1 : IDLE;
         WAIT1: begin
            if (c_done1_i) begin
               if (dc1_q[DC_STATUS_BIT]) begin
                  start_wr  = 1'b1;
                  start_adr = ctl_adr1_q;
                  state_n   = CTL1;
               end else begin
                  state_n   = TR1;
               end
            end
         end
         CTL1: if (last_beat) state_n = TR1;
         TR1: state_n = dc1_q[DC_LINK_BIT] ? NEXT1 : IDLE;
         NEXT1: begin
            start_rd = 1'b1;  // chain on into stage 0
            state_n  = CMD0;
         end
         default: state_n = IDLE;
      endcase
   end

   assign run1_start = (state_q == CMD1) && last_beat;
   assign int_set    = ((state_q == TR0) && dc0_q[DC_IRQ_BIT]) ||
                       ((state_q == TR1) && dc1_q[DC_IRQ_BIT]);

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q            <= IDLE;
         cyc_q              <= 1'b0;
         stb_q              <= 1'b0;
         we_q               <= 1'b0;
         append_mode_q      <= 1'b0;
         ndar_dirty_clear_o <= 1'b0;
         append_clear_o     <= 1'b0;
         stg0_run_o         <= 1'b0;
         stg1_run_o         <= 1'b0;
         dar_q              <= '0;
         wb_int_o           <= 1'b0;
      end else begin
         state_q            <= state_n;
         append_mode_q      <= append_mode_n;
         ndar_dirty_clear_o <= dirty_clear_n;
         append_clear_o     <= append_clear_n;
         if (start_rd || start_wr) begin
            cyc_q <= 1'b1;
            stb_q <= 1'b1;
            we_q  <= start_wr;
         end else if (last_beat) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
            we_q  <= 1'b0;
         end
         if (run0_start)
            stg0_run_o <= 1'b1;
         else if (state_q == TR0)
            stg0_run_o <= 1'b0;
         if (run1_start)
            stg1_run_o <= 1'b1;
         else if (state_q == TR1)
            stg1_run_o <= 1'b0;
         if (state_q == TR0)
            dar_q <= cdar0_q;
         else if (state_q == TR1)
            dar_q <= cdar1_q;
         if (int_set && !int_clear_i)
            wb_int_o <= 1'b1;
         else if (int_clear_i && !int_set)
            wb_int_o <= 1'b0;  // set and clear together hold
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (start_rd || start_wr) begin
         adr_q  <= start_adr;
         beat_q <= '0;
      end else if (ack_ok) begin
         adr_q  <= adr_q + 1'b1;  // next 64-bit word
         beat_q <= beat_q + 1'b1;
      end
      if (ack_ok && (state_q == CMD0 || state_q == CMD1)) begin
         if (beat_q == beat_t'(DC_PTR_BEAT)) begin
            next_desc_q <= wbm_dat_lo_i[31:3];
            if (state_q == CMD0) begin
               cdar0_q    <= adr_q;
               ctl_adr0_q <= wbm_dat_hi_i[31:3];
            end else begin
               cdar1_q    <= adr_q;
               ctl_adr1_q <= wbm_dat_hi_i[31:3];
            end
         end
         if (beat_q == beat_t'(DC_CTL_BEAT)) begin
            if (state_q == CMD0)
               dc0_q <= wbm_dat_lo_i[23:0];
            else
               dc1_q <= wbm_dat_lo_i[23:0];
         end
      end
      cyc0_q <= run0_start ? '0 : cyc0_q + 1'b1;  // cycles since run rose
      cyc1_q <= run1_start ? '0 : cyc1_q + 1'b1;
   end

   // status record, one word per beat
   always_comb begin
      stat_ocnt = (state_q == CTL1) ? ocnt1_i : ocnt0_i;
      stat_cyc  = (state_q == CTL1) ? cyc1_q : cyc0_q;
      stat_dc   = (state_q == CTL1) ? dc1_q : dc0_q;
      case (beat_q)
         2'd0:    stat_word = wb_dat_t'({stat_ocnt, 3'b000});
         2'd1:    stat_word = '0;  // error word, always clean here
         2'd2:    stat_word = stat_cyc;
         default: stat_word = wb_dat_t'(stat_dc);
      endcase
   end

   assign wbm_cyc_o    = cyc_q;
   assign wbm_stb_o    = stb_q;
   assign wbm_we_o     = we_q;
   assign wbm_cab_o    = cyc_q;  // every cycle is a burst
   assign wbm_sel_o    = WB_SEL_ALL;
   assign wbm_adr_o    = {adr_q, 3'b000};
   assign wbm_dat_lo_o = stat_word;
   assign wbm_dat_hi_o = '0;  // record words fit the low half

   assign stg0_we_o   = (state_q == CMD0) && ack_ok && !append_mode_q;
   assign stg1_we_o   = (state_q == CMD1) && ack_ok;
   assign stg_adr_o   = beat_q;
   assign stg_dat_o   = wbm_dat_lo_i;
   assign stg0_done_o = (state_q == TR0);
   assign stg1_done_o = (state_q == TR1);

   assign busy_o = (state_q != IDLE);
   assign dar_o  = {dar_q, 3'b000};

endmodule

// File: dma_top.sv
`timescale 1ns/100ps

module dma_top (
   input  logic                 wb_clk_i,
   input  logic                 wb_rst_i,
   input  logic                 reg_we_i,
   input  dma_bus_pkg::reg_adr_t reg_adr_i,
   input  dma_bus_pkg::wb_dat_t reg_dat_i,
   output dma_bus_pkg::wb_dat_t reg_dat_o,
   output logic                 wbm_cyc_o,
   output logic                 wbm_stb_o,
   output logic                 wbm_we_o,
   output logic                 wbm_cab_o,
   output dma_bus_pkg::wb_sel_t wbm_sel_o,
   output dma_bus_pkg::wb_adr_t wbm_adr_o,
   output dma_bus_pkg::wb_dat_t wbm_dat_lo_o,
   output dma_bus_pkg::wb_dat_t wbm_dat_hi_o,
   input  dma_bus_pkg::wb_dat_t wbm_dat_lo_i,
   input  dma_bus_pkg::wb_dat_t wbm_dat_hi_i,
   input  logic                 wbm_ack_i,
   input  logic                 wbm_err_i,
   input  logic                 wbm_rty_i,
   output logic                 busy_o,
   output logic                 wb_int_o
);
   import dma_bus_pkg::*;
   import dma_desc_pkg::*;

   desc_ptr_t ndar;
   logic      ndar_dirty;
   logic      ndar_dirty_clear;
   logic      enable;
   logic      append;
   logic      append_clear;
   logic      int_clear;
   wb_adr_t   dar;
   logic      stg0_we;
   logic      stg1_we;
   beat_t     stg_adr;
   wb_dat_t   stg_dat;
   logic      stg0_run;
   logic      stg1_run;
   logic      stg0_done;
   logic      stg1_done;
   logic      c_done0;
   logic      c_done1;
   ocnt_t     ocnt0;
   ocnt_t     ocnt1;

   dma_regs regs_i (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
      .reg_we_i(reg_we_i), .reg_adr_i(reg_adr_i),
      .reg_dat_i(reg_dat_i), .reg_dat_o(reg_dat_o),
      .ndar_o(ndar), .ndar_dirty_o(ndar_dirty),
      .ndar_dirty_clear_i(ndar_dirty_clear),
      .enable_o(enable), .append_o(append),
      .append_clear_i(append_clear), .int_clear_o(int_clear),
      .dar_i(dar), .busy_i(busy_o)
   );

   dma_ctrl ctrl_i (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
      .wbm_cyc_o(wbm_cyc_o), .wbm_stb_o(wbm_stb_o),
      .wbm_we_o(wbm_we_o), .wbm_cab_o(wbm_cab_o),
      .wbm_sel_o(wbm_sel_o), .wbm_adr_o(wbm_adr_o),
      .wbm_dat_lo_o(wbm_dat_lo_o), .wbm_dat_hi_o(wbm_dat_hi_o),
      .wbm_dat_lo_i(wbm_dat_lo_i), .wbm_dat_hi_i(wbm_dat_hi_i),
      .wbm_ack_i(wbm_ack_i), .wbm_err_i(wbm_err_i), .wbm_rty_i(wbm_rty_i),
      .ndar_i(ndar), .ndar_dirty_i(ndar_dirty),
      .ndar_dirty_clear_o(ndar_dirty_clear),
      .enable_i(enable), .append_i(append),
      .append_clear_o(append_clear), .int_clear_i(int_clear),
      .dar_o(dar),
      .stg0_we_o(stg0_we), .stg1_we_o(stg1_we),
      .stg_adr_o(stg_adr), .stg_dat_o(stg_dat),
      .stg0_run_o(stg0_run), .stg1_run_o(stg1_run),
      .stg0_done_o(stg0_done), .stg1_done_o(stg1_done),
      .c_done0_i(c_done0), .c_done1_i(c_done1),
      .ocnt0_i(ocnt0), .ocnt1_i(ocnt1),
      .busy_o(busy_o), .wb_int_o(wb_int_o)
   );

   dma_stage stage0_i (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
      .stg_we_i(stg0_we), .stg_adr_i(stg_adr), .stg_dat_i(stg_dat),
      .stg_run_i(stg0_run), .stg_done_i(stg0_done),
      .c_done_o(c_done0), .ocnt_o(ocnt0)
   );

   dma_stage stage1_i (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
      .stg_we_i(stg1_we), .stg_adr_i(stg_adr), .stg_dat_i(stg_dat),
      .stg_run_i(stg1_run), .stg_done_i(stg1_done),
      .c_done_o(c_done1), .ocnt_o(ocnt1)
   );

endmodule

// File: tb_wb_mem.sv
`timescale 1ns/100ps

module tb_wb_mem (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic        we_i,
   input  logic [31:0] adr_i,
   input  logic [31:0] dat_lo_i,
   input  logic [31:0] dat_hi_i,
   output logic [31:0] dat_lo_o,
   output logic [31:0] dat_hi_o,
   output logic        ack_o
);
   logic [63:0] mem [256];       // 64-bit words, 2 KB
   logic [31:0] log_adr [1024];  // every acked beat, in order
   logic        log_we [1024];
   int          log_cnt = 0;
   logic [31:0] rnd_q;
   logic [1:0]  wait_q;
   logic        armed_q;
   logic        hit;
   logic [7:0]  idx;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic load_word(input int i, input logic [63:0] v);
      mem[i] = v;
   endtask

   function automatic logic [63:0] peek_word(input int i);
      return mem[i];
   endfunction

   initial begin : fill
      int i;
      for (i = 0; i < 256; i++)
         mem[i] = {~(32'(i) << 3), 32'(i) << 3};  // byte address and its inverse
   end

   assign idx = adr_i[10:3];
   // ack after 0..3 wait states, picked when a beat first shows up
   assign hit = cyc_i && stb_i && !ack_o &&
                (armed_q ? (wait_q == 2'd1) : (rnd_q[1:0] == 2'd0));

   always @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         ack_o    <= 1'b0;
         armed_q  <= 1'b0;
         wait_q   <= '0;
         rnd_q    <= 32'd10;  // seed
         dat_lo_o <= '0;
         dat_hi_o <= '0;
      end else begin
         ack_o <= hit;
         if (cyc_i && stb_i && !ack_o) begin
            if (!armed_q) begin
               rnd_q   <= xorshift32(rnd_q);
               wait_q  <= rnd_q[1:0];
               armed_q <= !hit;
            end else if (hit) begin
               armed_q <= 1'b0;
            end else begin
               wait_q <= wait_q - 1'b1;
            end
         end
         if (hit && !we_i) begin
            dat_lo_o <= mem[idx][31:0];
            dat_hi_o <= mem[idx][63:32];
         end
      end
   end

   always @(posedge wb_clk_i) begin
      if (hit && !wb_rst_i) begin
         if (we_i)
            mem[idx] <= {dat_hi_i, dat_lo_i};
         log_adr[log_cnt] <= adr_i;
         log_we[log_cnt]  <= we_i;
         log_cnt          <= log_cnt + 1;
      end
   end

endmodule

// File: dma_assertions.sv
`timescale 1ns/100ps

module dma_assertions (
   input  logic                      wb_clk_i,
   input  logic                      wb_rst_i,
   input  logic                      cyc_i,
   input  logic                      stb_i,
   input  logic                      ack_i,
   input  dma_bus_pkg::wb_adr_t      adr_i,
   input  logic                      busy_i,
   input  dma_desc_pkg::ctrl_state_e state_i
);
   import dma_bus_pkg::*;
   import dma_desc_pkg::*;

   int         fail_cnt = 0;
   logic [2:0] acks_q;  // acks seen in the current bus cycle

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i)
         acks_q <= '0;
      else if (!cyc_i)
         acks_q <= '0;
      else if (ack_i)
         acks_q <= acks_q + 1'b1;
   end

   stb_needs_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      stb_i |-> (cyc_i && acks_q < 3'(BURST_BEATS)))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("wbm_stb_o high outside a four-beat bus cycle");
      end

   burst_len: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $fell(cyc_i) |-> (acks_q == 3'(BURST_BEATS)))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("wbm_cyc_o dropped without exactly four acks");
      end

   adr_held: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (stb_i && !ack_i) |=> $stable(adr_i))  // beat address waits for ack
      else begin
         fail_cnt = fail_cnt + 1;
         $error("wbm_adr_o moved without an ack");
      end

   idle_not_busy: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (state_i == IDLE) |-> (!busy_i && !cyc_i))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("busy_o or wbm_cyc_o high in IDLE");
      end

endmodule

bind dma_ctrl dma_assertions asrt_i (
   .wb_clk_i(wb_clk_i),
   .wb_rst_i(wb_rst_i),
   .cyc_i(wbm_cyc_o),
   .stb_i(wbm_stb_o),
   .ack_i(wbm_ack_i),
   .adr_i(wbm_adr_o),
   .busy_i(busy_o),
   .state_i(state_q)
);

// File: tb_dma.sv
`timescale 1ns/100ps

module tb_dma;
   import dma_bus_pkg::*;
   import dma_desc_pkg::*;

   localparam int N_ROWS  = 4;
   localparam int N_DESC  = 6;
   localparam int JOB_MAX = 3000;  // cycles allowed for one job

   logic     wb_clk_i;
   logic     wb_rst_i;
   logic     reg_we_i;
   reg_adr_t reg_adr_i;
   wb_dat_t  reg_dat_i;
   wb_dat_t  reg_dat_o;
   logic     wbm_cyc;
   logic     wbm_stb;
   logic     wbm_we;
   logic     wbm_cab;
   wb_sel_t  wbm_sel;
   wb_adr_t  wbm_adr;
   wb_dat_t  wbm_dat_lo_w;
   wb_dat_t  wbm_dat_hi_w;
   wb_dat_t  wbm_dat_lo_r;
   wb_dat_t  wbm_dat_hi_r;
   logic     wbm_ack;
   logic     wbm_err;
   logic     wbm_rty;
   logic     busy_o;
   logic     wb_int_o;
   int       errors = 0;
   int       checks = 0;

   // descriptor table, one entry per descriptor image to preload
   int       d_row [N_DESC];
   wb_adr_t  d_adr [N_DESC];
   wb_adr_t  d_next [N_DESC];
   wb_adr_t  d_stat [N_DESC];
   int       d_len [N_DESC];
   logic     d_link [N_DESC];
   logic     d_irq [N_DESC];
   logic     d_st [N_DESC];
   logic     d_chk [N_DESC];  // status record checked in its row
   // scenario table
   int       r_wr_cnt [N_ROWS];
   reg_adr_t r_wr_adr [N_ROWS][3];
   wb_dat_t  r_wr_dat [N_ROWS][3];
   logic     r_late [N_ROWS];  // enable comes after an idle check
   int       r_nfetch [N_ROWS];
   wb_adr_t  r_fetch [N_ROWS][2];
   wb_adr_t  r_dar [N_ROWS];
   logic     r_int [N_ROWS];

   dma_top dut_i (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
      .reg_we_i(reg_we_i), .reg_adr_i(reg_adr_i),
      .reg_dat_i(reg_dat_i), .reg_dat_o(reg_dat_o),
      .wbm_cyc_o(wbm_cyc), .wbm_stb_o(wbm_stb), .wbm_we_o(wbm_we), .wbm_cab_o(wbm_cab),
      .wbm_sel_o(wbm_sel), .wbm_adr_o(wbm_adr),
      .wbm_dat_lo_o(wbm_dat_lo_w), .wbm_dat_hi_o(wbm_dat_hi_w),
      .wbm_dat_lo_i(wbm_dat_lo_r), .wbm_dat_hi_i(wbm_dat_hi_r),
      .wbm_ack_i(wbm_ack), .wbm_err_i(wbm_err), .wbm_rty_i(wbm_rty),
      .busy_o(busy_o), .wb_int_o(wb_int_o)
   );

   tb_wb_mem mem_i (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
      .cyc_i(wbm_cyc), .stb_i(wbm_stb), .we_i(wbm_we), .adr_i(wbm_adr),
      .dat_lo_i(wbm_dat_lo_w), .dat_hi_i(wbm_dat_hi_w),
      .dat_lo_o(wbm_dat_lo_r), .dat_hi_o(wbm_dat_hi_r), .ack_o(wbm_ack)
   );

   always #20 wb_clk_i = ~wb_clk_i;

   // every transfer is a full-width burst
   always @(negedge wb_clk_i) begin
      if (wbm_cyc === 1'b1) begin
         check_val("wbm_sel_o", 64'(wbm_sel), 64'hf);
         check_val("wbm_cab_o", 64'(wbm_cab), 64'h1);
      end
   end

   task automatic add_desc(input int i, input int row, input wb_adr_t adr, input wb_adr_t nxt,
                           input wb_adr_t stat, input int len, input logic link,
                           input logic irq, input logic st, input logic chk);
      d_row[i]  = row;
      d_adr[i]  = adr;
      d_next[i] = nxt;
      d_stat[i] = stat;
      d_len[i]  = len;
      d_link[i] = link;
      d_irq[i]  = irq;
      d_st[i]   = st;
      d_chk[i]  = chk;
   endtask

   task automatic add_row(input int r, input logic late, input int nf, input wb_adr_t f0,
                          input wb_adr_t f1, input wb_adr_t dar, input logic irq);
      r_late[r]     = late;
      r_nfetch[r]   = nf;
      r_fetch[r][0] = f0;
      r_fetch[r][1] = f1;
      r_dar[r]      = dar;
      r_int[r]      = irq;
   endtask

   task automatic add_write(input int r, input reg_adr_t a, input wb_dat_t d);
      r_wr_adr[r][r_wr_cnt[r]] = a;
      r_wr_dat[r][r_wr_cnt[r]] = d;
      r_wr_cnt[r]++;
   endtask

   task automatic build_table();
      int r;
      for (r = 0; r < N_ROWS; r++)
         r_wr_cnt[r] = 0;
      // single descriptor, no flags
      add_desc(0, 0, 32'h100, 32'h0, 32'h500, 5, 1'b0, 1'b0, 1'b0, 1'b0);
      add_row(0, 1'b0, 1, 32'h100, 32'h0, 32'h100, 1'b0);
      add_write(0, REG_CSR, 32'h1);
      add_write(0, REG_NDAR, 32'h100);
      // linked pair with status records, irq on the first
      add_desc(1, 1, 32'h200, 32'h280, 32'h600, 3, 1'b1, 1'b1, 1'b1, 1'b1);
      add_desc(2, 1, 32'h280, 32'h0, 32'h680, 4, 1'b0, 1'b0, 1'b1, 1'b1);
      add_row(1, 1'b0, 2, 32'h200, 32'h280, 32'h280, 1'b1);
      add_write(1, REG_NDAR, 32'h200);
      // append: last descriptor patched with a link
      add_desc(3, 2, 32'h280, 32'h300, 32'h680, 4, 1'b1, 1'b0, 1'b1, 1'b0);
      add_desc(4, 2, 32'h300, 32'h0, 32'h700, 2, 1'b0, 1'b1, 1'b1, 1'b1);
      add_row(2, 1'b0, 2, 32'h280, 32'h300, 32'h300, 1'b1);
      add_write(2, REG_CSR, 32'h3);
      // ndar written while disabled
      add_desc(5, 3, 32'h380, 32'h0, 32'h780, 1, 1'b0, 1'b0, 1'b0, 1'b0);
      add_row(3, 1'b1, 1, 32'h380, 32'h0, 32'h380, 1'b0);
      add_write(3, REG_CSR, 32'h0);
      add_write(3, REG_NDAR, 32'h380);
   endtask

   function automatic desc_ctl_t make_ctl(input int i);
      desc_ctl_t c;
      c = '0;
      c[DC_LEN_LSB +: 8] = 8'(d_len[i]);
      c[DC_LINK_BIT]     = d_link[i];
      c[DC_IRQ_BIT]      = d_irq[i];
      c[DC_STATUS_BIT]   = d_st[i];
      return c;
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic reg_write(input reg_adr_t a, input wb_dat_t d);
      @(posedge wb_clk_i);
      reg_we_i  <= 1'b1;
      reg_adr_i <= a;
      reg_dat_i <= d;
      @(posedge wb_clk_i);
      reg_we_i  <= 1'b0;
   endtask

   task automatic reg_read(input reg_adr_t a, output wb_dat_t d);
      @(posedge wb_clk_i);
      reg_adr_i <= a;
      @(negedge wb_clk_i);
      d = reg_dat_o;  // combinational readback
   endtask

   task automatic wait_busy(input logic level, input int limit);
      int n;
      n = 0;
      while (busy_o !== level && n < limit) begin
         @(negedge wb_clk_i);
         n++;
      end
      if (busy_o !== level) begin
         errors++;
         $display("Timeout at %0t: busy_o never went to %b", $time, level);
      end
   endtask

   task automatic wait_int_low(input int limit);
      int n;
      n = 0;
      while (wb_int_o !== 1'b0 && n < limit) begin
         @(negedge wb_clk_i);
         n++;
      end
      checks++;
      if (wb_int_o !== 1'b0) begin
         errors++;
         $display("Timeout at %0t: wb_int_o stayed high after an interrupt clear", $time);
      end
   endtask

   task automatic load_desc(input int i);
      int w;
      w = int'(d_adr[i] >> 3);
      mem_i.load_word(w, {d_stat[i], d_next[i]});
      mem_i.load_word(w + 1, {32'h0, 8'h0, make_ctl(i)});
   endtask

   task automatic check_reads(input int r, input int base);
      int n;
      int k;
      wb_adr_t exp_adr;
      n = 0;
      for (k = base; k < mem_i.log_cnt; k++) begin
         if (!mem_i.log_we[k]) begin
            if (n < 4 * r_nfetch[r]) begin
               exp_adr = r_fetch[r][n / 4] + wb_adr_t'(8 * (n % 4));  // 4 beats, 8 bytes each
               check_val("wbm_adr_o", mem_i.log_adr[k], exp_adr);
            end
            n++;
         end
      end
      check_val("read beat count", n, 4 * r_nfetch[r]);
   endtask

   task automatic check_status(input int i);
      int w;
      logic [63:0] third;
      w = int'(d_stat[i] >> 3);
      check_val("status word 0", mem_i.peek_word(w), d_len[i] * 8);
      check_val("status word 1", mem_i.peek_word(w + 1), 32'h0);
      third = mem_i.peek_word(w + 2);
      check_val("status word 2 high half", third[63:32], 32'h0);
      checks++;
      if (third[31:0] < d_len[i]) begin
         errors++;
         $display("Error at %0t: status word 2 got %h expected at least %h",
                  $time, third[31:0], d_len[i]);
      end
      check_val("status word 3", mem_i.peek_word(w + 3), 32'(make_ctl(i)));
   endtask

   task automatic run_row(input int r);
      int i;
      int k;
      int base;
      wb_dat_t v;
      for (i = 0; i < N_DESC; i++)
         if (d_row[i] == r)
            load_desc(i);
      base = mem_i.log_cnt;
      for (i = 0; i < r_wr_cnt[r]; i++)
         reg_write(r_wr_adr[r][i], r_wr_dat[r][i]);
      if (r_late[r]) begin
         for (k = 0; k < 20; k++) begin
            @(negedge wb_clk_i);
            check_val("busy_o", 32'(busy_o), 32'h0);
         end
         check_val("beats while disabled", mem_i.log_cnt - base, 32'h0);
         reg_write(REG_CSR, 32'h1);
      end
      wait_busy(1'b1, 50);
      wait_busy(1'b0, JOB_MAX);
      check_reads(r, base);
      reg_read(REG_DAR, v);
      check_val("reg_dat_o (dar)", v, r_dar[r]);
      check_val("wb_int_o", 32'(wb_int_o), 32'(r_int[r]));
      for (i = 0; i < N_DESC; i++)
         if (d_row[i] == r && d_chk[i])
            check_status(i);
      if (wb_int_o) begin
         reg_write(REG_INTCLR, 32'h0);
         wait_int_low(20);
      end
   endtask

   initial begin
      int r;
      int asrt_fails;
      wb_clk_i  = 1'b0;
      wb_rst_i  = 1'b1;
      reg_we_i  = 1'b0;
      reg_adr_i = '0;
      reg_dat_i = '0;
      wbm_err   = 1'b0;
      wbm_rty   = 1'b0;
      build_table();
      repeat (10) @(posedge wb_clk_i);
      wb_rst_i <= 1'b0;
      for (r = 0; r < N_ROWS; r++)
         run_row(r);
      asrt_fails = dut_i.ctrl_i.asrt_i.fail_cnt;
      $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt_fails);
      if (errors == 0 && asrt_fails == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: all.f
dma_bus_pkg.sv
dma_desc_pkg.sv
dma_regs.sv
dma_stage.sv
dma_ctrl.sv
dma_top.sv
tb_wb_mem.sv
dma_assertions.sv
tb_dma.sv
